// ==== hdl/lrelu_cfg_pkg.sv ====
package lrelu_cfg_pkg;

  localparam int MEMBERS = 4;  // coefficient members per beat
  localparam int KW_MAX  = 7;  // largest kernel width, odd
  localparam int WORD_W  = 16;

  localparam int BITS_KW2   = $clog2(KW_MAX / 2 + 1);
  localparam int BITS_KH    = (KW_MAX > 1) ? $clog2(KW_MAX) : 1;  // mtb up to KW_MAX-1
  localparam int BITS_CLR_I = $clog2(KW_MAX / 2 + 1);

  function automatic int ceil_div(int num, int den);
    return (num + den - 1) / den;
  endfunction

  // beats in one BRAM B group, never zero
  function automatic int calc_beats_b(int clr_i, int kw2, int members);
    int beats;
    beats = ceil_div(2 * (kw2 - clr_i + 1), members);
    return (beats < 1) ? 1 : beats;
  endfunction

  function automatic int calc_beats_max(int kw_max, int members);
    int best;
    best = 0;
    for (int k = 0; k <= kw_max / 2; k++) begin
      if (ceil_div(2 * k + 1, 2) > best) begin  // BRAM A group
        best = ceil_div(2 * k + 1, 2);
      end
      for (int c = 0; c <= k; c++) begin
        if (calc_beats_b(c, k, members) > best) begin
          best = calc_beats_b(c, k, members);
        end
      end
    end
    return best + 1;
  endfunction

  localparam int BITS_W_ADDR = $clog2(calc_beats_max(KW_MAX, MEMBERS));

  typedef enum logic [1:0] {
    W_IDLE   = 2'd0,
    W_REG_D  = 2'd1,
    W_BRAM_A = 2'd2,
    W_BRAM_B = 2'd3
  } w_sel_e;

endpackage

// ==== hdl/lrelu_data_pkg.sv ====
package lrelu_data_pkg;

  typedef logic [lrelu_cfg_pkg::WORD_W-1:0] cfg_word_t;

  typedef struct packed {
    logic                                     en;
    lrelu_cfg_pkg::w_sel_e                    sel;
    logic [lrelu_cfg_pkg::BITS_CLR_I-1:0]     clr_i;
    logic [lrelu_cfg_pkg::BITS_KH-1:0]        mtb;
    logic [lrelu_cfg_pkg::BITS_W_ADDR-1:0]    w_addr;
    cfg_word_t                                data;
  } wr_cmd_t;

  typedef struct packed {
    logic [lrelu_cfg_pkg::WORD_W-lrelu_cfg_pkg::WORD_W/2-1:0] alpha;  // upper half
    logic [lrelu_cfg_pkg::WORD_W/2-1:0]                       shift;  // lower half
  } d_param_t;

  // read address layout used by BRAM B
  typedef struct packed {
    logic [lrelu_cfg_pkg::BITS_CLR_I-1:0]  clr_i;
    logic [lrelu_cfg_pkg::BITS_KH-1:0]     mtb;
    logic [lrelu_cfg_pkg::BITS_W_ADDR-1:0] beat;
  } bram_b_addr_t;

  typedef struct packed {
    logic                             en;
    lrelu_cfg_pkg::w_sel_e            sel;
    logic [$bits(bram_b_addr_t)-1:0]  addr;
  } rd_req_t;

  typedef struct packed {
    logic      valid;
    cfg_word_t data;
  } rd_rsp_t;

endpackage

// ==== hdl/lrelu_beats_counter.sv ====
`timescale 1ns/1ps

module lrelu_beats_counter #(
  parameter int KW_MAX  = lrelu_cfg_pkg::KW_MAX,
  parameter int MEMBERS = lrelu_cfg_pkg::MEMBERS
) (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               en_i,
  input  logic [lrelu_cfg_pkg::BITS_KW2-1:0] kw2_i,
  input  lrelu_data_pkg::cfg_word_t          cfg_data_i,
  output lrelu_data_pkg::wr_cmd_t            wr_o,
  output logic                               full_o
);
  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int KW2_MAX = KW_MAX / 2;

  w_sel_e                 w_sel_q;
  w_sel_e                 w_sel_d;
  logic [BITS_CLR_I-1:0]  clr_i_q;
  logic [BITS_KH-1:0]     mtb_q;
  logic [BITS_W_ADDR-1:0] w_addr_q;

  logic clr_i_last;
  logic mtb_last;
  logic a_last;
  logic b_last;
  logic en_w_addr;
  logic en_mtb;
  logic en_clr_i;
  logic en_w_sel;

  // last beat index per group, indexed by kw2 (and clr_i for BRAM B)
  logic [BITS_W_ADDR-1:0] lut_a [KW2_MAX+1];
  logic [BITS_W_ADDR-1:0] lut_b [KW2_MAX+1][KW2_MAX+1];

  for (genvar k = 0; k <= KW2_MAX; k++) begin : g_lut_kw2
    assign lut_a[k] = BITS_W_ADDR'(ceil_div(2 * k + 1, 2) - 1);
    for (genvar c = 0; c <= KW2_MAX; c++) begin : g_lut_clr
      if (c <= k) begin : g_used
        assign lut_b[k][c] = BITS_W_ADDR'(calc_beats_b(c, k, MEMBERS) - 1);
      end else begin : g_unused
        assign lut_b[k][c] = '0;  // clr_i never passes kw2
      end
    end
  end

  assign clr_i_last = clr_i_q == kw2_i;
  assign mtb_last   = mtb_q == BITS_KH'({clr_i_q, 1'b0});  // rows 0..2*clr_i
  assign a_last     = (w_sel_q == W_BRAM_A) && (w_addr_q == lut_a[kw2_i]);
  assign b_last     = (w_sel_q == W_BRAM_B) && (w_addr_q == lut_b[kw2_i][clr_i_q]);

  assign full_o = en_i && b_last && mtb_last && clr_i_last;

  // inner counters gate the outer ones
  assign en_w_addr = en_i && (w_sel_q != W_REG_D);
  assign en_mtb    = en_w_addr && b_last;
  assign en_clr_i  = en_mtb && mtb_last;

  always_comb begin
    case (w_sel_q)
      W_REG_D:  w_sel_d = W_BRAM_A;
      W_BRAM_A: w_sel_d = W_BRAM_B;
      W_BRAM_B: w_sel_d = W_REG_D;
      default:  w_sel_d = W_REG_D;
    endcase
  end

  always_comb begin
    case (w_sel_q)
      W_REG_D:  en_w_sel = en_i;  // D is a single beat
      W_BRAM_A: en_w_sel = en_w_addr && a_last;
      W_BRAM_B: en_w_sel = en_clr_i && clr_i_last;
      default:  en_w_sel = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_sel_q  <= W_REG_D;
      clr_i_q  <= '0;
      mtb_q    <= '0;
      w_addr_q <= '0;
    end else begin
      if (en_w_sel) begin
        w_sel_q <= w_sel_d;
      end
      if (en_clr_i) begin
        clr_i_q <= clr_i_last ? '0 : clr_i_q + 1'b1;
      end
      if (en_mtb) begin
        mtb_q <= mtb_last ? '0 : mtb_q + 1'b1;
      end
      if (en_w_addr) begin
        w_addr_q <= (a_last || b_last) ? '0 : w_addr_q + 1'b1;
      end
    end
  end

  always_comb begin
    wr_o.en     = en_i;
    wr_o.sel    = w_sel_q;
    wr_o.clr_i  = clr_i_q;
    wr_o.mtb    = mtb_q;
    wr_o.w_addr = w_addr_q;
    wr_o.data   = cfg_data_i;
  end

  a_no_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    w_sel_q != W_IDLE);

  // kw2_i is held for the whole frame
  a_clr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    clr_i_q <= kw2_i);

  a_full_in_b: assert property (@(posedge clk) disable iff (!rst_n_i)
    full_o |-> w_sel_q == W_BRAM_B);

endmodule

// ==== hdl/lrelu_reg_d.sv ====
`timescale 1ns/1ps

module lrelu_reg_d #(
  parameter int WORD_W = lrelu_cfg_pkg::WORD_W
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  lrelu_data_pkg::wr_cmd_t  wr_i,
  input  lrelu_data_pkg::rd_req_t  rd_req_i,
  output lrelu_data_pkg::d_param_t d_o,
  output lrelu_data_pkg::rd_rsp_t  rd_rsp_o
);
  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int SHIFT_W = WORD_W / 2;

  d_param_t d_q;
  logic     rd_valid_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      d_q        <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (wr_i.en && (wr_i.sel == W_REG_D)) begin
        d_q.shift <= wr_i.data[SHIFT_W-1:0];
        d_q.alpha <= wr_i.data[WORD_W-1:SHIFT_W];
      end
      rd_valid_q <= rd_req_i.en && (rd_req_i.sel == W_REG_D);  // address ignored
    end
  end

  assign d_o = d_q;

  // zero when idle so the top can OR the answers
  assign rd_rsp_o.valid = rd_valid_q;
  assign rd_rsp_o.data  = rd_valid_q ? d_q : '0;

endmodule

// ==== hdl/lrelu_bram_a.sv ====
`timescale 1ns/1ps

module lrelu_bram_a #(
  parameter int KW_MAX = lrelu_cfg_pkg::KW_MAX,
  parameter int WORD_W = lrelu_cfg_pkg::WORD_W
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  lrelu_data_pkg::wr_cmd_t wr_i,
  input  lrelu_data_pkg::rd_req_t rd_req_i,
  output lrelu_data_pkg::rd_rsp_t rd_rsp_o
);
  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int DEPTH  = (KW_MAX + 1) / 2;  // ceil(KW_MAX/2) beats
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WORD_W-1:0] mem [DEPTH];
  logic [WORD_W-1:0] rd_data_q;
  logic              rd_valid_q;
  logic              wr_hit;
  logic              rd_hit;

  assign wr_hit = wr_i.en && (wr_i.sel == W_BRAM_A);
  assign rd_hit = rd_req_i.en && (rd_req_i.sel == W_BRAM_A);

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_i.w_addr[ADDR_W-1:0]] <= wr_i.data;
    end
    if (rd_hit) begin
      rd_data_q <= mem[rd_req_i.addr[ADDR_W-1:0]];  // beat in low bits
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_hit;
    end
  end

  assign rd_rsp_o.valid = rd_valid_q;
  assign rd_rsp_o.data  = rd_valid_q ? rd_data_q : '0;

  // counter limits must keep BRAM A writes in range
  a_wr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_hit |-> int'(wr_i.w_addr) <= DEPTH - 1);

endmodule

// ==== hdl/lrelu_bram_b.sv ====
`timescale 1ns/1ps

module lrelu_bram_b #(
  parameter int KW_MAX  = lrelu_cfg_pkg::KW_MAX,
  parameter int MEMBERS = lrelu_cfg_pkg::MEMBERS,
  parameter int WORD_W  = lrelu_cfg_pkg::WORD_W
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  lrelu_data_pkg::wr_cmd_t wr_i,
  input  lrelu_data_pkg::rd_req_t rd_req_i,
  output lrelu_data_pkg::rd_rsp_t rd_rsp_o
);
  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int CLR_N   = KW_MAX / 2 + 1;
  localparam int MTB_N   = KW_MAX;
  localparam int BEATS_N = calc_beats_max(KW_MAX, MEMBERS);
  localparam int DEPTH   = CLR_N * MTB_N * BEATS_N;
  localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WORD_W-1:0] mem [DEPTH];
  logic [WORD_W-1:0] rd_data_q;
  logic              rd_valid_q;
  logic              wr_hit;
  logic              rd_hit;
  bram_b_addr_t      rd_addr;
  logic [ADDR_W-1:0] wr_lin;
  logic [ADDR_W-1:0] rd_lin;

  // row-major over clr_i, mtb, beat
  function automatic logic [ADDR_W-1:0] lin_addr(
    input logic [BITS_CLR_I-1:0]  clr_i,
    input logic [BITS_KH-1:0]     mtb,
    input logic [BITS_W_ADDR-1:0] beat
  );
    return ADDR_W'((int'(clr_i) * MTB_N + int'(mtb)) * BEATS_N + int'(beat));
  endfunction

  assign wr_hit  = wr_i.en && (wr_i.sel == W_BRAM_B);
  assign rd_hit  = rd_req_i.en && (rd_req_i.sel == W_BRAM_B);
  assign rd_addr = bram_b_addr_t'(rd_req_i.addr);
  assign wr_lin  = lin_addr(wr_i.clr_i, wr_i.mtb, wr_i.w_addr);
  assign rd_lin  = lin_addr(rd_addr.clr_i, rd_addr.mtb, rd_addr.beat);

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_lin] <= wr_i.data;
    end
    if (rd_hit) begin
      rd_data_q <= mem[rd_lin];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_hit;
    end
  end

  assign rd_rsp_o.valid = rd_valid_q;
  assign rd_rsp_o.data  = rd_valid_q ? rd_data_q : '0;

  // fill rows for a clear index stop at 2*clr_i
  a_mtb_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_hit |-> int'(wr_i.mtb) <= 2 * int'(wr_i.clr_i));

endmodule

// ==== hdl/lrelu_cfg_top.sv ====
`timescale 1ns/1ps

module lrelu_cfg_top #(
  parameter int KW_MAX  = lrelu_cfg_pkg::KW_MAX,
  parameter int MEMBERS = lrelu_cfg_pkg::MEMBERS,
  parameter int WORD_W  = lrelu_cfg_pkg::WORD_W
) (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               cfg_en_i,
  input  lrelu_data_pkg::cfg_word_t          cfg_data_i,
  input  logic [lrelu_cfg_pkg::BITS_KW2-1:0] kw2_i,
  input  lrelu_data_pkg::rd_req_t            rd_req_i,
  output logic                               full_o,
  output lrelu_data_pkg::d_param_t           d_o,
  output lrelu_data_pkg::rd_rsp_t            rd_rsp_o
);
  import lrelu_data_pkg::*;

  wr_cmd_t wr;
  rd_rsp_t rsp_d;
  rd_rsp_t rsp_a;
  rd_rsp_t rsp_b;

  lrelu_beats_counter #(
    .KW_MAX  (KW_MAX),
    .MEMBERS (MEMBERS)
  ) u_counter (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .en_i       (cfg_en_i),
    .kw2_i      (kw2_i),
    .cfg_data_i (cfg_data_i),
    .wr_o       (wr),
    .full_o     (full_o)
  );

  lrelu_reg_d #(
    .WORD_W (WORD_W)
  ) u_reg_d (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wr_i     (wr),
    .rd_req_i (rd_req_i),
    .d_o      (d_o),
    .rd_rsp_o (rsp_d)
  );

  lrelu_bram_a #(
    .KW_MAX (KW_MAX),
    .WORD_W (WORD_W)
  ) u_bram_a (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wr_i     (wr),
    .rd_req_i (rd_req_i),
    .rd_rsp_o (rsp_a)
  );

  lrelu_bram_b #(
    .KW_MAX  (KW_MAX),
    .MEMBERS (MEMBERS),
    .WORD_W  (WORD_W)
  ) u_bram_b (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wr_i     (wr),
    .rd_req_i (rd_req_i),
    .rd_rsp_o (rsp_b)
  );

  assign rd_rsp_o = rsp_d | rsp_a | rsp_b;  // only the selected block answers

endmodule

// ==== dv/lrelu_cfg_model.svh ====
`ifndef LRELU_CFG_MODEL_SVH
`define LRELU_CFG_MODEL_SVH

localparam int M_KW2_MAX = KW_MAX / 2;
localparam int M_A_N     = (KW_MAX + 1) / 2;
localparam int M_CLR_N   = KW_MAX / 2 + 1;
localparam int M_BEAT_N  = KW_MAX + 1;  // loose bound on beats per group

int        error_cnt;
int        check_cnt;
cfg_word_t exp_d;
cfg_word_t exp_a [M_A_N];
bit        has_a [M_A_N];
cfg_word_t exp_b [M_CLR_N][KW_MAX][M_BEAT_N];
bit        has_b [M_CLR_N][KW_MAX][M_BEAT_N];
cfg_word_t frame_q [$];

function automatic int model_beats_a(input int kw2);
  return kw2 + 1;  // ceil((2*kw2+1)/2)
endfunction

function automatic int model_beats_b(input int clr, input int kw2);
  int beats;
  beats = (2 * (kw2 - clr + 1) + MEMBERS - 1) / MEMBERS;
  if (beats < 1) begin
    beats = 1;
  end
  return beats;
endfunction

// one frame in arrival order: D, BRAM A, then BRAM B groups
task automatic build_frame(input int kw2);
  cfg_word_t w;
  frame_q.delete();
  w = cfg_word_t'($random(seed));
  frame_q.push_back(w);
  exp_d = w;
  for (int b = 0; b < model_beats_a(kw2); b++) begin
    w = cfg_word_t'($random(seed));
    frame_q.push_back(w);
    exp_a[b] = w;
    has_a[b] = 1'b1;
  end
  for (int c = 0; c <= kw2; c++) begin
    for (int m = 0; m <= 2 * c; m++) begin
      for (int b = 0; b < model_beats_b(c, kw2); b++) begin
        w = cfg_word_t'($random(seed));
        frame_q.push_back(w);
        exp_b[c][m][b] = w;
        has_b[c][m][b] = 1'b1;
      end
    end
  end
endtask

task automatic check_d(input d_param_t got, input d_param_t exp, input string what);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp, input string what);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("MISMATCH at %0t: %s, got valid %b data %h expected valid %b data %h",
             $time, what, got.valid, got.data, exp.valid, exp.data);
  end
endtask

task automatic check_full(input logic got, input logic exp, input string what);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("MISMATCH at %0t: %s, full_o is %b expected %b", $time, what, got, exp);
  end
endtask

`endif

// ==== dv/lrelu_cfg_tb.sv ====
`timescale 1ns/1ps

module lrelu_cfg_tb;
  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int RD_ADDR_W    = $bits(bram_b_addr_t);
  localparam int READ_TIMEOUT = 8;

  typedef logic [RD_ADDR_W-1:0] rd_addr_t;

  logic                clk;
  logic                rst_n;
  logic                cfg_en;
  cfg_word_t           cfg_data;
  logic [BITS_KW2-1:0] kw2;
  rd_req_t             rd_req;
  logic                full;
  d_param_t            d_out;
  rd_rsp_t             rd_rsp;

  int seed;
  int test_cnt;
  int test_fail;

  `include "lrelu_cfg_model.svh"

  lrelu_cfg_top #(
    .KW_MAX  (KW_MAX),
    .MEMBERS (MEMBERS),
    .WORD_W  (WORD_W)
  ) UUT (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .cfg_en_i   (cfg_en),
    .cfg_data_i (cfg_data),
    .kw2_i      (kw2),
    .rd_req_i   (rd_req),
    .full_o     (full),
    .d_o        (d_out),
    .rd_rsp_o   (rd_rsp)
  );

  always #2 clk = ~clk;

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cfg_en <= 1'b0;
      @(negedge clk);
      check_full(full, 1'b0, "full_o during idle cycle");
    end
  endtask

  // words of frame_q, with random idle gaps of up to max_gap cycles
  // cfg_en stays high after the last word so a new frame can follow at once
  task automatic send_words(input int k, input int count, input int max_gap);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
      idle_cycles(gap);
      @(posedge clk);
      cfg_en   <= 1'b1;
      cfg_data <= frame_q[i];
      kw2      <= BITS_KW2'(k);
      @(negedge clk);
      check_full(full, logic'(i == frame_q.size() - 1), $sformatf("word %0d of frame", i));
    end
  endtask

  task automatic read_block(input w_sel_e sel, input rd_addr_t addr, output rd_rsp_t rsp);
    rd_req_t req;
    int      wait_cnt;
    req.en   = 1'b1;
    req.sel  = sel;
    req.addr = addr;
    @(posedge clk);
    rd_req <= req;
    @(posedge clk);
    rd_req <= '0;
    wait_cnt = 0;
    @(negedge clk);
    while (!rd_rsp.valid && wait_cnt < READ_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rd_rsp.valid) begin
      error_cnt++;
      $display("read of %s got no response within %0d cycles", sel.name(), READ_TIMEOUT);
    end else if (wait_cnt != 0) begin
      error_cnt++;
      $display("read of %s answered after %0d cycles instead of one",
               sel.name(), wait_cnt + 1);
    end
    rsp = rd_rsp;
  endtask

  task automatic verify_contents();
    rd_rsp_t      got;
    rd_rsp_t      exp;
    bram_b_addr_t ba;
    check_d(d_out, d_param_t'(exp_d), "d_o");
    read_block(W_REG_D, '0, got);
    exp.valid = 1'b1;
    exp.data  = exp_d;
    check_rsp(got, exp, "read of D register");
    for (int b = 0; b < M_A_N; b++) begin
      if (has_a[b]) begin
        read_block(W_BRAM_A, RD_ADDR_W'(b), got);
        exp.data = exp_a[b];
        check_rsp(got, exp, $sformatf("BRAM A beat %0d", b));
      end
    end
    for (int c = 0; c < M_CLR_N; c++) begin
      for (int m = 0; m <= 2 * c; m++) begin
        for (int b = 0; b < M_BEAT_N; b++) begin
          if (has_b[c][m][b]) begin
            ba.clr_i = BITS_CLR_I'(c);
            ba.mtb   = BITS_KH'(m);
            ba.beat  = BITS_W_ADDR'(b);
            read_block(W_BRAM_B, rd_addr_t'(ba), got);
            exp.data = exp_b[c][m][b];
            check_rsp(got, exp, $sformatf("BRAM B clr %0d mtb %0d beat %0d", c, m, b));
          end
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (error_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - err_before);
    end
  endtask

  initial begin
    rd_rsp_t got;
    int      err_before;
    int      k;
    int      cut;
    seed     = 32'h35a6;
    clk      = 1'b0;
    rst_n    = 1'b0;
    cfg_en   = 1'b0;
    cfg_data = '0;
    kw2      = '0;
    rd_req   = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    err_before = error_cnt;
    @(negedge clk);
    check_rsp(rd_rsp, '0, "response after reset");
    check_d(d_out, '0, "d_o after reset");
    idle_cycles(4);
    read_block(W_REG_D, '0, got);
    check_rsp(got, rd_rsp_t'({1'b1, cfg_word_t'(0)}), "D register after reset");
    read_block(W_BRAM_A, '0, got);  // memories are not reset, only the answer counts
    read_block(W_BRAM_B, '0, got);
    end_test("reset state", err_before);

    for (int i = 0; i <= M_KW2_MAX; i++) begin
      err_before = error_cnt;
      build_frame(i);
      send_words(i, frame_q.size(), 0);
      idle_cycles(1);
      verify_contents();
      end_test($sformatf("frame with kw2 %0d", i), err_before);
    end

    err_before = error_cnt;
    for (int f = 0; f < 4; f++) begin
      k = int'($unsigned($random(seed)) % (M_KW2_MAX + 1));
      build_frame(k);
      send_words(k, frame_q.size(), (f % 2 == 0) ? 3 : 0);  // odd frames back to back
    end
    idle_cycles(1);
    verify_contents();
    end_test("gapped and back-to-back frames", err_before);

    err_before = error_cnt;
    k = M_KW2_MAX;
    build_frame(k);
    cut = 1 + int'($unsigned($random(seed)) % (frame_q.size() - 2));
    send_words(k, cut, 2);
    idle_cycles(1);
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_d(d_out, '0, "d_o after reset in mid-frame");
    build_frame(k);
    send_words(k, frame_q.size(), 1);
    idle_cycles(1);
    verify_contents();
    end_test("reset in mid-frame", err_before);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+dv
hdl/lrelu_cfg_pkg.sv
hdl/lrelu_data_pkg.sv
hdl/lrelu_beats_counter.sv
hdl/lrelu_reg_d.sv
hdl/lrelu_bram_a.sv
hdl/lrelu_bram_b.sv
hdl/lrelu_cfg_top.sv
dv/lrelu_cfg_tb.sv

// ==== Makefile ====
# Verilator build and run for the leaky-ReLU configuration loader

VERILATOR ?= verilator
TOP       ?= lrelu_cfg_tb
SEED      ?= 0
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "*** TEST FAILED ***" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
